/* sources.f */
+incdir+testbench
design/dbg_mon_pkg.sv
design/trace_router.sv
design/hart_debug_tracker.sv
design/dbg_mon_regs.sv
design/dbg_mon_top.sv
testbench/tb_dbg_mon.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug monitor testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f sources.f --top-module tb_dbg_mon -o sim_dbg_mon
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_dbg_mon > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -F -q '*** FAILED ***' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

exit 0

/* testbench/dbg_mon_ref.svh */
`ifndef DBG_MON_REF_SVH
`define DBG_MON_REF_SVH

// Instruction words used as stimulus
localparam logic [31:0] INSN_EBREAK  = 32'h0010_0073;
localparam logic [31:0] INSN_CEBREAK = 32'h0000_9002;
localparam logic [31:0] INSN_DRET    = 32'h7b20_0073;
localparam logic [31:0] INSN_ADDI    = 32'h0000_0013;

// Expected configuration and status of every hart
dbg_mon_pkg::hart_cfg_t    model_cfg [dbg_mon_pkg::NUM_HARTS];
dbg_mon_pkg::hart_status_t model_st  [dbg_mon_pkg::NUM_HARTS];

// Status of one hart after it retires one instruction
function automatic dbg_mon_pkg::hart_status_t next_status(
  input dbg_mon_pkg::hart_status_t cur,
  input dbg_mon_pkg::hart_cfg_t    cfg,
  input logic [31:0]               pc,
  input logic [31:0]               next_pc,
  input logic [31:0]               instr,
  input logic                      err,
  input logic                      hreq
);
  dbg_mon_pkg::hart_status_t nxt;
  logic                      brk;
  logic                      ret;
  logic                      enter;
  nxt   = cur;
  enter = 1'b0;
  brk   = !err && ((instr == INSN_EBREAK) || (instr == INSN_CEBREAK));
  ret   = !err && (instr == INSN_DRET);
  if (cur.state == dbg_mon_pkg::ST_HALTED) begin
    // Only dret matters in debug mode
    if (ret) begin
      nxt.state = dbg_mon_pkg::ST_RUNNING;
    end
  end else if (cfg.trig_en && (pc == cfg.tdata2)) begin
    enter     = 1'b1;
    nxt.cause = dbg_mon_pkg::CAUSE_TRIGGER;
    nxt.dpc   = pc;
  end else if (brk && cfg.ebreakm) begin
    enter     = 1'b1;
    nxt.cause = dbg_mon_pkg::CAUSE_EBREAK;
    nxt.dpc   = pc;
  end else if (hreq) begin
    enter     = 1'b1;
    nxt.cause = dbg_mon_pkg::CAUSE_HALTREQ;
    nxt.dpc   = next_pc;
  end else if (cfg.step) begin
    enter     = 1'b1;
    nxt.cause = dbg_mon_pkg::CAUSE_STEP;
    nxt.dpc   = next_pc;
  end else if (ret) begin
    nxt.ill_drets = cur.ill_drets + 16'd1;
  end
  // Every cause taken while running is one debug entry
  if (enter) begin
    nxt.state   = dbg_mon_pkg::ST_HALTED;
    nxt.entries = cur.entries + 16'd1;
  end
  return nxt;
endfunction

`endif

/* testbench/tb_dbg_mon.sv */
module tb_dbg_mon;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                cov_assert_if;
  logic                                arst_n;
  dbg_mon_pkg::trace_beat_t            trace;
  logic [dbg_mon_pkg::NUM_HARTS-1:0]   haltreq;
  logic                                wb_cyc;
  logic                                wb_stb;
  logic                                wb_we;
  logic [dbg_mon_pkg::ADR_W-1:0]       wb_adr;
  logic [dbg_mon_pkg::XLEN-1:0]        wb_dat_w;
  logic [dbg_mon_pkg::XLEN-1:0]        wb_dat_r;
  logic                                wb_ack;
  integer                              seed;
  int                                  issued = 0;
  int                                  cycles = 0;
  int                                  errors = 0;

  `include "dbg_mon_ref.svh"

  dbg_mon_top dut (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n),
    .trace_i       (trace),
    .haltreq_i     (haltreq),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .wb_dat_o      (wb_dat_r),
    .wb_ack_o      (wb_ack)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #10 cov_assert_if = ~cov_assert_if;
  end

  // Budget of 40 cycles per operation issued
  always @(posedge cov_assert_if) begin
    cycles = cycles + 1;
    if (cycles > 40 * issued + 1000) begin
      $display("Timeout after %0d cycles with %0d operations issued", cycles, issued);
      $display("*** FAILED ***");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // ------------------------------
  // Wishbone host
  // ------------------------------
  task automatic wb_access(input logic we, input int hart, input logic [2:0] offs,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge cov_assert_if);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = {hart[dbg_mon_pkg::HART_W-1:0], offs};
    wb_dat_w = wdata;
    issued++;
    do begin
      @(negedge cov_assert_if);
    end while (!wb_ack);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_check(input string name, input int hart, input logic [2:0] offs,
                            input logic [31:0] exp);
    logic [31:0] rdata;
    wb_access(1'b0, hart, offs, 32'h0, rdata);
    compare($sformatf("%s, hart %0d, offset %0d", name, hart, offs), exp, rdata);
  endtask

  task automatic write_ctrl(input int hart, input logic step, input logic ebreakm,
                            input logic trig_en);
    logic [31:0] data;
    logic [31:0] unused;
    data = '0;
    data[dbg_mon_pkg::CTRL_STEP_BIT]    = step;
    data[dbg_mon_pkg::CTRL_EBREAKM_BIT] = ebreakm;
    data[dbg_mon_pkg::CTRL_TRIG_EN_BIT] = trig_en;
    wb_access(1'b1, hart, dbg_mon_pkg::REG_CTRL, data, unused);
    model_cfg[hart].step    = step;
    model_cfg[hart].ebreakm = ebreakm;
    model_cfg[hart].trig_en = trig_en;
  endtask

  task automatic write_tdata2(input int hart, input logic [31:0] value);
    logic [31:0] unused;
    wb_access(1'b1, hart, dbg_mon_pkg::REG_TDATA2, value, unused);
    model_cfg[hart].tdata2 = value;
  endtask

  // Every register of every hart against the model
  task automatic check_all(input string name);
    for (int h = 0; h < dbg_mon_pkg::NUM_HARTS; h++) begin
      read_check(name, h, dbg_mon_pkg::REG_CTRL, {29'd0, model_cfg[h].trig_en,
                 model_cfg[h].ebreakm, model_cfg[h].step});
      read_check(name, h, dbg_mon_pkg::REG_TDATA2, model_cfg[h].tdata2);
      read_check(name, h, dbg_mon_pkg::REG_STATUS, {28'd0, model_st[h].cause,
                 model_st[h].state});
      read_check(name, h, dbg_mon_pkg::REG_DPC, model_st[h].dpc);
      read_check(name, h, dbg_mon_pkg::REG_ENTRIES, {16'd0, model_st[h].entries});
      read_check(name, h, dbg_mon_pkg::REG_ILL_DRET, {16'd0, model_st[h].ill_drets});
    end
  endtask

  // ------------------------------
  // Trace port
  // ------------------------------
  // Haltreq stays up until the tracker has seen the routed beat
  task automatic send_beat(input int hart, input logic [31:0] pc, input logic [31:0] next_pc,
                           input logic [31:0] instr, input logic err, input logic hreq);
    @(negedge cov_assert_if);
    trace.valid   = 1'b1;
    trace.err     = err;
    trace.hart    = hart[dbg_mon_pkg::HART_W-1:0];
    trace.pc      = pc;
    trace.next_pc = next_pc;
    trace.instr   = instr;
    haltreq[hart] = hreq;
    issued++;
    @(negedge cov_assert_if);
    trace.valid = 1'b0;
    @(negedge cov_assert_if);
    haltreq = '0;
    model_st[hart] = next_status(model_st[hart], model_cfg[hart], pc, next_pc, instr, err, hreq);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] rdata;
    logic [31:0] pc;
    logic [31:0] instr;
    int          h;
    arst_n   = 1'b0;
    trace    = '0;
    haltreq  = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    seed     = 32'hdc05bde6;
    for (int i = 0; i < dbg_mon_pkg::NUM_HARTS; i++) begin
      model_cfg[i] = '0;
      model_st[i]  = '0;
    end
    repeat (4) @(posedge cov_assert_if);
    @(negedge cov_assert_if);
    arst_n = 1'b1;

    // Reset values and register readback
    check_all("reset values");
    for (int i = 0; i < dbg_mon_pkg::NUM_HARTS; i++) begin
      wb_access(1'b1, i, dbg_mon_pkg::REG_CTRL, 32'hffff_ffff, rdata);
      read_check("control readback", i, dbg_mon_pkg::REG_CTRL, 32'h0000_0007);
      write_tdata2(i, $random(seed));
      read_check("tdata2 readback", i, dbg_mon_pkg::REG_TDATA2, model_cfg[i].tdata2);
      wb_access(1'b1, i, 3'd6, 32'hffff_ffff, rdata);
      read_check("unused offset", i, 3'd6, 32'h0);
      write_ctrl(i, 1'b0, 1'b0, 1'b0);
    end
    check_all("after readback");

    // ebreak and c.ebreak entry
    write_ctrl(0, 1'b0, 1'b1, 1'b0);
    send_beat(0, 32'h100, 32'h104, INSN_EBREAK, 1'b0, 1'b0);
    read_check("ebreak cause", 0, dbg_mon_pkg::REG_STATUS, 32'h3);
    read_check("ebreak dpc", 0, dbg_mon_pkg::REG_DPC, 32'h100);
    write_ctrl(1, 1'b0, 1'b1, 1'b0);
    send_beat(1, 32'h200, 32'h202, INSN_CEBREAK, 1'b1, 1'b0);
    read_check("faulted c.ebreak", 1, dbg_mon_pkg::REG_ENTRIES, 32'h0);
    send_beat(1, 32'h202, 32'h204, INSN_CEBREAK, 1'b0, 1'b0);
    read_check("c.ebreak cause", 1, dbg_mon_pkg::REG_STATUS, 32'h3);
    send_beat(2, 32'h300, 32'h304, INSN_EBREAK, 1'b0, 1'b0);
    read_check("ebreak without ebreakm", 2, dbg_mon_pkg::REG_ENTRIES, 32'h0);
    check_all("ebreak entry");

    // dret in and out of debug mode
    send_beat(0, 32'h400, 32'h404, INSN_DRET, 1'b0, 1'b0);
    read_check("dret resume", 0, dbg_mon_pkg::REG_STATUS, 32'h2);
    read_check("dret keeps dpc", 0, dbg_mon_pkg::REG_DPC, 32'h100);
    send_beat(3, 32'h500, 32'h504, INSN_DRET, 1'b0, 1'b0);
    read_check("illegal dret", 3, dbg_mon_pkg::REG_ILL_DRET, 32'h1);
    check_all("dret");

    // Trigger over ebreak
    send_beat(1, 32'h204, 32'h208, INSN_DRET, 1'b0, 1'b0);
    write_tdata2(1, 32'h600);
    write_ctrl(1, 1'b0, 1'b1, 1'b1);
    send_beat(1, 32'h600, 32'h604, INSN_EBREAK, 1'b0, 1'b0);
    read_check("trigger over ebreak", 1, dbg_mon_pkg::REG_STATUS, 32'h5);
    read_check("trigger dpc", 1, dbg_mon_pkg::REG_DPC, 32'h600);
    send_beat(1, 32'h700, 32'h704, INSN_DRET, 1'b0, 1'b0);
    write_ctrl(1, 1'b0, 1'b0, 1'b0);
    send_beat(1, 32'h600, 32'h604, INSN_ADDI, 1'b0, 1'b0);
    read_check("trigger disabled", 1, dbg_mon_pkg::REG_ENTRIES, 32'h2);
    check_all("trigger");

    // Haltreq over step, then step alone
    write_ctrl(2, 1'b1, 1'b0, 1'b0);
    send_beat(2, 32'h800, 32'h804, INSN_ADDI, 1'b0, 1'b1);
    read_check("haltreq over step", 2, dbg_mon_pkg::REG_STATUS, 32'h7);
    read_check("haltreq dpc", 2, dbg_mon_pkg::REG_DPC, 32'h804);
    send_beat(2, 32'h804, 32'h808, INSN_DRET, 1'b0, 1'b0);
    send_beat(2, 32'h808, 32'h80c, INSN_ADDI, 1'b0, 1'b0);
    read_check("step cause", 2, dbg_mon_pkg::REG_STATUS, 32'h9);
    read_check("step dpc", 2, dbg_mon_pkg::REG_DPC, 32'h80c);
    send_beat(2, 32'h80c, 32'h810, INSN_DRET, 1'b0, 1'b0);
    write_ctrl(2, 1'b0, 1'b0, 1'b0);
    check_all("haltreq and step");

    // Random stream, pc and tdata2 drawn from eight words so triggers hit
    for (int n = 1; n <= 300; n++) begin
      r = $random(seed);
      h = int'(r[1:0]);
      if (r[4:2] == 3'd0) begin
        write_ctrl(h, r[5], r[6], r[7]);
      end
      if (r[10:8] == 3'd0) begin
        write_tdata2(h, 32'h1000 + {r[13:11], 2'b00});
      end
      pc = 32'h1000 + {r[16:14], 2'b00};
      case (r[18:17])
        2'd0:    instr = INSN_EBREAK;
        2'd1:    instr = INSN_CEBREAK;
        2'd2:    instr = INSN_DRET;
        default: instr = INSN_ADDI;
      endcase
      send_beat(h, pc, pc + 32'd4, instr, r[21:19] == 3'd0, r[23:22] == 2'd0);
      if (n % 50 == 0) begin
        check_all($sformatf("random stream beat %0d", n));
      end
    end
    check_all("random stream end");

    if (errors == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "Checks failed");
    end
  end

endmodule : tb_dbg_mon

/* design/dbg_mon_top.sv */
module dbg_mon_top (
  input  logic                                cov_assert_if,
  input  logic                                arst_n_i,
  input  dbg_mon_pkg::trace_beat_t            trace_i,
  input  logic [dbg_mon_pkg::NUM_HARTS-1:0]   haltreq_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [dbg_mon_pkg::ADR_W-1:0]       wb_adr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]        wb_dat_i,
  output logic [dbg_mon_pkg::XLEN-1:0]        wb_dat_o,
  output logic                                wb_ack_o
);

  dbg_mon_pkg::hart_beat_t   beats  [dbg_mon_pkg::NUM_HARTS];
  dbg_mon_pkg::hart_cfg_t    cfg    [dbg_mon_pkg::NUM_HARTS];
  dbg_mon_pkg::hart_status_t status [dbg_mon_pkg::NUM_HARTS];

  trace_router u_router (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .trace_i       (trace_i),
    .beats_o       (beats)
  );

  // One tracker per hart
  for (genvar g = 0; g < dbg_mon_pkg::NUM_HARTS; g++) begin : g_hart
    hart_debug_tracker u_tracker (
      .cov_assert_if (cov_assert_if),
      .arst_n_i      (arst_n_i),
      .beat_i        (beats[g]),
      .cfg_i         (cfg[g]),
      .haltreq_i     (haltreq_i[g]),
      .status_o      (status[g])
    );
  end

  dbg_mon_regs u_regs (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .status_i      (status),
    .cfg_o         (cfg)
  );

endmodule : dbg_mon_top

/* design/dbg_mon_regs.sv */
module dbg_mon_regs (
  input  logic                            cov_assert_if,
  input  logic                            arst_n_i,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [dbg_mon_pkg::ADR_W-1:0]   wb_adr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]    wb_dat_i,
  output logic [dbg_mon_pkg::XLEN-1:0]    wb_dat_o,
  output logic                            wb_ack_o,
  input  dbg_mon_pkg::hart_status_t       status_i [dbg_mon_pkg::NUM_HARTS],
  output dbg_mon_pkg::hart_cfg_t          cfg_o [dbg_mon_pkg::NUM_HARTS]
);

  logic                              ack_q;
  logic [dbg_mon_pkg::XLEN-1:0]      dat_q;
  logic                              req;
  logic [dbg_mon_pkg::HART_W-1:0]    hart_sel;
  logic [dbg_mon_pkg::OFFS_W-1:0]    offs;
  logic [dbg_mon_pkg::XLEN-1:0]      rd_data;
  dbg_mon_pkg::hart_cfg_t            cfg_q [dbg_mon_pkg::NUM_HARTS];

  // ------------------------------
  // Bus decode
  // ------------------------------
  // The cycle after ack is dead so a held strobe is not taken twice
  assign req      = wb_cyc_i && wb_stb_i && !ack_q;
  assign hart_sel = wb_adr_i[dbg_mon_pkg::ADR_W-1:dbg_mon_pkg::OFFS_W];
  assign offs     = wb_adr_i[dbg_mon_pkg::OFFS_W-1:0];

  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // ------------------------------
  // Configuration registers
  // ------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int h = 0; h < dbg_mon_pkg::NUM_HARTS; h++) begin
        cfg_q[h] <= '0;
      end
    end else if (req && wb_we_i) begin
      case (offs)
        dbg_mon_pkg::REG_CTRL: begin
          cfg_q[hart_sel].step    <= wb_dat_i[dbg_mon_pkg::CTRL_STEP_BIT];
          cfg_q[hart_sel].ebreakm <= wb_dat_i[dbg_mon_pkg::CTRL_EBREAKM_BIT];
          cfg_q[hart_sel].trig_en <= wb_dat_i[dbg_mon_pkg::CTRL_TRIG_EN_BIT];
        end
        dbg_mon_pkg::REG_TDATA2: begin
          cfg_q[hart_sel].tdata2 <= wb_dat_i;
        end
        // Status words are read only
        default: begin
        end
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rd_data = '0;
    case (offs)
      dbg_mon_pkg::REG_CTRL: begin
        rd_data[dbg_mon_pkg::CTRL_STEP_BIT]    = cfg_q[hart_sel].step;
        rd_data[dbg_mon_pkg::CTRL_EBREAKM_BIT] = cfg_q[hart_sel].ebreakm;
        rd_data[dbg_mon_pkg::CTRL_TRIG_EN_BIT] = cfg_q[hart_sel].trig_en;
      end
      dbg_mon_pkg::REG_TDATA2: begin
        rd_data = cfg_q[hart_sel].tdata2;
      end
      dbg_mon_pkg::REG_STATUS: begin
        // State in bit 0, dcsr-style cause above it
        rd_data[0]   = status_i[hart_sel].state;
        rd_data[3:1] = status_i[hart_sel].cause;
      end
      dbg_mon_pkg::REG_DPC: begin
        rd_data = status_i[hart_sel].dpc;
      end
      dbg_mon_pkg::REG_ENTRIES: begin
        rd_data[dbg_mon_pkg::CNT_W-1:0] = status_i[hart_sel].entries;
      end
      dbg_mon_pkg::REG_ILL_DRET: begin
        rd_data[dbg_mon_pkg::CNT_W-1:0] = status_i[hart_sel].ill_drets;
      end
      default: begin
      end
    endcase
  end

  // Captured with the request so data lines up with ack
  always_ff @(posedge cov_assert_if) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;

  a_ack_single_cycle: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    ack_q |=> !ack_q
  ) else $error("dbg_mon_regs: ack held for two cycles");

endmodule : dbg_mon_regs

/* design/hart_debug_tracker.sv */
module hart_debug_tracker (
  input  logic                      cov_assert_if,
  input  logic                      arst_n_i,
  input  dbg_mon_pkg::hart_beat_t   beat_i,
  input  dbg_mon_pkg::hart_cfg_t    cfg_i,
  input  logic                      haltreq_i,
  output dbg_mon_pkg::hart_status_t status_o
);

  dbg_mon_pkg::dbg_state_e          state_q;
  dbg_mon_pkg::dbg_cause_e          cause_q;
  logic [dbg_mon_pkg::XLEN-1:0]     dpc_q;
  logic [dbg_mon_pkg::CNT_W-1:0]    entries_q;
  logic [dbg_mon_pkg::CNT_W-1:0]    ill_drets_q;

  logic                             is_ebreak;
  logic                             is_dret;
  logic                             trig_hit;
  dbg_mon_pkg::dbg_cause_e          cause_sel;
  logic [dbg_mon_pkg::XLEN-1:0]     entry_dpc;

  // ------------------------------
  // Instruction and trigger match
  // ------------------------------
  assign is_ebreak = (beat_i.cls == dbg_mon_pkg::CLS_EBREAK) ||
                     (beat_i.cls == dbg_mon_pkg::CLS_CEBREAK);
  assign is_dret   = (beat_i.cls == dbg_mon_pkg::CLS_DRET);

  // Address trigger on the retiring pc
  assign trig_hit  = cfg_i.trig_en && (beat_i.pc == cfg_i.tdata2);

  // ------------------------------
  // Cause priority
  // ------------------------------
  // Trigger beats ebreak, ebreak beats haltreq, haltreq beats step.
  // Haltreq is only sampled when this hart retires an instruction
  always_comb begin
    if (trig_hit) begin
      cause_sel = dbg_mon_pkg::CAUSE_TRIGGER;
    end else if (is_ebreak && cfg_i.ebreakm) begin
      cause_sel = dbg_mon_pkg::CAUSE_EBREAK;
    end else if (haltreq_i) begin
      cause_sel = dbg_mon_pkg::CAUSE_HALTREQ;
    end else if (cfg_i.step) begin
      cause_sel = dbg_mon_pkg::CAUSE_STEP;
    end else begin
      cause_sel = dbg_mon_pkg::CAUSE_NONE;
    end
  end

  // Trigger and ebreak halt before the instruction, the others after it
  always_comb begin
    if ((cause_sel == dbg_mon_pkg::CAUSE_TRIGGER) ||
        (cause_sel == dbg_mon_pkg::CAUSE_EBREAK)) begin
      entry_dpc = beat_i.pc;
    end else begin
      entry_dpc = beat_i.next_pc;
    end
  end

  // ------------------------------
  // Debug state
  // ------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= dbg_mon_pkg::ST_RUNNING;
      cause_q     <= dbg_mon_pkg::CAUSE_NONE;
      dpc_q       <= '0;
      entries_q   <= '0;
      ill_drets_q <= '0;
    end else if (beat_i.valid) begin
      if (state_q == dbg_mon_pkg::ST_RUNNING) begin
        if (cause_sel != dbg_mon_pkg::CAUSE_NONE) begin
          state_q   <= dbg_mon_pkg::ST_HALTED;
          cause_q   <= cause_sel;
          dpc_q     <= entry_dpc;
          entries_q <= entries_q + 1'b1;
        end else if (is_dret) begin
          // dret outside debug mode is illegal
          ill_drets_q <= ill_drets_q + 1'b1;
        end
      end else if (is_dret) begin
        // Resume; cause and dpc stay readable for the host
        state_q <= dbg_mon_pkg::ST_RUNNING;
      end
      // Any other beat while halted is ignored, ebreak included
    end
  end

  assign status_o.state     = state_q;
  assign status_o.cause     = cause_q;
  assign status_o.dpc       = dpc_q;
  assign status_o.entries   = entries_q;
  assign status_o.ill_drets = ill_drets_q;

  // ------------------------------
  // Assertions
  // ------------------------------
  a_halted_has_cause: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    (state_q == dbg_mon_pkg::ST_HALTED) |-> (cause_q != dbg_mon_pkg::CAUSE_NONE)
  ) else $error("hart_debug_tracker: halted without a debug cause");

endmodule : hart_debug_tracker

/* design/trace_router.sv */
module trace_router (
  input  logic                     cov_assert_if,
  input  logic                     arst_n_i,
  input  dbg_mon_pkg::trace_beat_t trace_i,
  output dbg_mon_pkg::hart_beat_t  beats_o [dbg_mon_pkg::NUM_HARTS]
);

  dbg_mon_pkg::insn_class_e            cls;
  logic [dbg_mon_pkg::NUM_HARTS-1:0]   hit;
  logic [dbg_mon_pkg::NUM_HARTS-1:0]   valid_q;
  logic [dbg_mon_pkg::XLEN-1:0]        pc_q;
  logic [dbg_mon_pkg::XLEN-1:0]        next_pc_q;
  dbg_mon_pkg::insn_class_e            cls_q;

  // ------------------------------
  // Decode
  // ------------------------------
  // A faulted fetch never counts as a debug instruction
  always_comb begin
    if (trace_i.err) begin
      cls = dbg_mon_pkg::CLS_OTHER;
    end else if (trace_i.instr == dbg_mon_pkg::EBREAK_OPCODE) begin
      cls = dbg_mon_pkg::CLS_EBREAK;
    end else if (trace_i.instr == dbg_mon_pkg::CEBREAK_OPCODE) begin
      cls = dbg_mon_pkg::CLS_CEBREAK;
    end else if (trace_i.instr == dbg_mon_pkg::DRET_OPCODE) begin
      cls = dbg_mon_pkg::CLS_DRET;
    end else begin
      cls = dbg_mon_pkg::CLS_OTHER;
    end
  end

  // One-hot slot select from the hart tag
  always_comb begin
    hit = '0;
    if (trace_i.valid) begin
      hit[trace_i.hart] = 1'b1;
    end
  end

  // ------------------------------
  // Output stage
  // ------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= hit;
    end
  end

  // Only one slot is valid per cycle, so all slots share one payload
  always_ff @(posedge cov_assert_if) begin
    if (trace_i.valid) begin
      pc_q      <= trace_i.pc;
      next_pc_q <= trace_i.next_pc;
      cls_q     <= cls;
    end
  end

  always_comb begin
    for (int h = 0; h < dbg_mon_pkg::NUM_HARTS; h++) begin
      beats_o[h].valid   = valid_q[h];
      beats_o[h].pc      = pc_q;
      beats_o[h].next_pc = next_pc_q;
      beats_o[h].cls     = cls_q;
    end
  end

  a_one_slot_valid: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    $onehot0(valid_q)
  ) else $error("trace_router: more than one hart beat valid");

endmodule : trace_router

/* design/dbg_mon_pkg.sv */
package dbg_mon_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int NUM_HARTS = 4;
  localparam int HART_W    = 2;
  localparam int XLEN      = 32;
  localparam int CNT_W     = 16;

  // One hart owns a block of 8 words on the host bus
  localparam int OFFS_W = 3;
  localparam int ADR_W  = HART_W + OFFS_W;

  // ------------------------------
  // Instruction encodings
  // ------------------------------
  localparam logic [31:0] EBREAK_OPCODE  = 32'h0010_0073;
  // Compressed form sits in the low half, upper half zero
  localparam logic [31:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [31:0] DRET_OPCODE    = 32'h7B20_0073;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [OFFS_W-1:0] REG_CTRL     = 3'd0;
  localparam logic [OFFS_W-1:0] REG_TDATA2   = 3'd1;
  localparam logic [OFFS_W-1:0] REG_STATUS   = 3'd2;
  localparam logic [OFFS_W-1:0] REG_DPC      = 3'd3;
  localparam logic [OFFS_W-1:0] REG_ENTRIES  = 3'd4;
  localparam logic [OFFS_W-1:0] REG_ILL_DRET = 3'd5;

  // Control word fields
  localparam int CTRL_STEP_BIT    = 0;
  localparam int CTRL_EBREAKM_BIT = 1;
  localparam int CTRL_TRIG_EN_BIT = 2;

  // ------------------------------
  // Types
  // ------------------------------
  typedef enum logic [1:0] {
    CLS_OTHER,
    CLS_EBREAK,
    CLS_CEBREAK,
    CLS_DRET
  } insn_class_e;

  // Same numbering as the dcsr.cause field
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  typedef enum logic {
    ST_RUNNING,
    ST_HALTED
  } dbg_state_e;

  // Retired instruction as seen on the shared trace port
  typedef struct packed {
    logic              valid;
    logic              err;
    logic [HART_W-1:0] hart;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   next_pc;
    logic [31:0]       instr;
  } trace_beat_t;

  // Decoded beat for one hart
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    insn_class_e     cls;
  } hart_beat_t;

  typedef struct packed {
    logic            step;
    logic            ebreakm;
    logic            trig_en;
    logic [XLEN-1:0] tdata2;
  } hart_cfg_t;

  typedef struct packed {
    dbg_state_e       state;
    dbg_cause_e       cause;
    logic [XLEN-1:0]  dpc;
    logic [CNT_W-1:0] entries;
    logic [CNT_W-1:0] ill_drets;
  } hart_status_t;

endpackage : dbg_mon_pkg
